/* flist.f */
logic/core_pkg.sv
logic/reg_file.sv
logic/decode_stage.sv
logic/execute_stage.sv
logic/memory_stage.sv
logic/ex_core_top.sv
tb/ex_core_checker.sv
tb/ex_core_tb.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f flist.f --top-module ex_core_tb -o ex_core_sim
./obj_dir/ex_core_sim > sim.log
cat sim.log
if grep -qx "Simulation passed" sim.log; then
	echo "result: pass"
else
	echo "result: fail"
	exit 1
fi

/* tb/ex_core_tb.sv */
module ex_core_tb
	import core_pkg::*;
();

	localparam logic [6:0] opc_imm  = 7'h13;
	localparam logic [6:0] opc_load = 7'h03;
	localparam logic [6:0] opc_jalr = 7'h67;

	logic            clk;
	logic            rst_n;
	logic            instr_valid;
	logic [31:0]     instr;
	logic [xlen-1:0] pc;
	logic            stall;
	logic            wb_valid;
	logic [4:0]      wb_rd;
	logic [xlen-1:0] wb_data;
	logic            br_taken;
	logic [xlen-1:0] br_target;
	int              fail_count;
	int              tb_fails;
	int              last_fails;
	int              tests;
	int              seed;
	logic [xlen-1:0] next_pc;

	ex_core_top u_ex_core_top (.*);

	ex_core_checker u_checker (.*);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2_i,
			input logic [4:0] rs1_i, input logic [2:0] f3, input logic [4:0] rd_i);
		return {f7, rs2_i, rs1_i, f3, rd_i, 7'h33};
	endfunction

	function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1_i,
			input logic [2:0] f3, input logic [4:0] rd_i, input logic [6:0] opc);
		return {imm, rs1_i, f3, rd_i, opc};
	endfunction

	function automatic logic [31:0] s_type(input logic [11:0] imm, input logic [4:0] rs2_i,
			input logic [4:0] rs1_i);
		return {imm[11:5], rs2_i, rs1_i, 3'b010, imm[4:0], 7'h23};
	endfunction

	function automatic logic [31:0] b_type(input logic [12:0] off, input logic [4:0] rs2_i,
			input logic [4:0] rs1_i, input logic [2:0] f3);
		return {off[12], off[10:5], rs2_i, rs1_i, f3, off[4:1], off[11], 7'h63};
	endfunction

	function automatic logic [31:0] u_type(input logic [19:0] imm, input logic [4:0] rd_i);
		return {imm, rd_i, 7'h37};
	endfunction

	// one instruction, then k stall cycles, then wait for its result
	task automatic issue(input logic [31:0] ins, input logic writes, input int k);
		int   lat;
		logic done;
		@(posedge clk);
		instr_valid <= 1'b1;
		instr <= ins;
		pc <= next_pc;
		next_pc = next_pc + 4;
		lat = 0;
		done = 1'b0;
		while (!done && lat < k + 20) begin
			@(posedge clk);
			lat++;
			instr_valid <= 1'b0;
			stall <= (lat <= k);
			done = writes ? wb_valid : (lat == k + 4);
		end
		if (!done) begin
			$display("timeout: no writeback for instruction %h after %0d cycles", ins, lat);
			$display("Simulation failed");
			$finish;
		end else if (writes) begin
			assert (lat == k + 4) else begin
				$display("[FAIL] t=%0t wb latency expected %0d got %0d", $time, k + 4, lat);
				tb_fails++;
			end
		end
	endtask

	// upper part rounded for the sign of the low twelve bits
	task automatic set_reg(input logic [4:0] rd_i, input logic [31:0] v);
		logic [19:0] hi;
		hi = v[31:12] + {19'b0, v[11]};
		issue(u_type(hi, rd_i), 1'b1, 0);
		issue(i_type(v[11:0], rd_i, 3'd0, rd_i, opc_imm), 1'b1, 0);
	endtask

	task automatic finish_test(input string name);
		int now_fails;
		now_fails = tb_fails + fail_count;
		tests++;
		$display("test %0d %s: %0d failed checks", tests, name, now_fails - last_fails);
		last_fails = now_fails;
	endtask

	initial begin
		logic [31:0] v;
		logic [11:0] imm;
		int          k;
		seed = 43417;
		tests = 0;
		tb_fails = 0;
		last_fails = 0;
		next_pc = 32'h100;
		rst_n = 1'b0;
		instr_valid = 1'b0;
		instr = '0;
		pc = '0;
		stall = 1'b0;
		repeat (5) @(posedge clk);
		rst_n <= 1'b1;
		@(posedge clk);
		@(posedge clk);
		assert (!wb_valid && !br_taken) else begin
			$display("[FAIL] t=%0t wb_valid,br_taken expected 0,0 got %0b,%0b",
				$time, wb_valid, br_taken);
			tb_fails++;
		end
		finish_test("reset");

		for (int r = 0; r < 3; r++) begin
			set_reg(5'd5, $random(seed));
			set_reg(5'd6, $random(seed));
			for (int f = 0; f < 8; f++) begin
				issue(r_type(7'h00, 5'd6, 5'd5, f[2:0], 5'd7), 1'b1, 0);
				v = $random(seed);
				imm = v[11:0];
				if (f == 1 || f == 5)
					imm[11:5] = 7'h00;
				issue(i_type(imm, 5'd5, f[2:0], 5'd8, opc_imm), 1'b1, 0);
			end
			// sub, sra and srai
			issue(r_type(7'h20, 5'd6, 5'd5, 3'd0, 5'd7), 1'b1, 0);
			issue(r_type(7'h20, 5'd6, 5'd5, 3'd5, 5'd7), 1'b1, 0);
			issue(i_type({7'h20, imm[4:0]}, 5'd5, 3'd5, 5'd8, opc_imm), 1'b1, 0);
		end
		finish_test("alu");

		for (int f = 0; f < 8; f++) begin
			if (f == 2 || f == 3)
				continue;
			for (int r = 0; r < 3; r++) begin
				v = $random(seed);
				set_reg(5'd5, v);
				// random, equal, then sign bit flipped
				set_reg(5'd6, r == 0 ? $random(seed) : r == 1 ? v : v ^ 32'h8000_0000);
				v = $random(seed);
				issue(b_type({v[11:0], 1'b0}, 5'd6, 5'd5, f[2:0]), 1'b0, 0);
			end
		end
		finish_test("branch");

		for (int r = 0; r < 2; r++) begin
			set_reg(5'd5, $random(seed));
			v = $random(seed);
			issue(i_type(v[11:0], 5'd5, 3'd0, 5'd9, opc_jalr), 1'b1, 0);
			issue(i_type(v[23:12], 5'd5, 3'd0, 5'd0, opc_jalr), 1'b1, 0);
			issue(i_type(12'h123, 5'd5, 3'd0, 5'd0, opc_imm), 1'b1, 0);
			issue(u_type(v[31:12], 5'd0), 1'b1, 0);
			issue(r_type(7'h00, 5'd0, 5'd0, 3'd0, 5'd10), 1'b1, 0);
			issue(b_type(13'h010, 5'd0, 5'd0, 3'd0), 1'b0, 0);
		end
		finish_test("jalr_x0");

		for (int r = 0; r < 4; r++) begin
			v = $random(seed);
			set_reg(5'd10, {22'b0, v[7:0], 2'b00});
			set_reg(5'd5, $random(seed));
			set_reg(5'd6, $random(seed));
			issue(s_type(12'h000, 5'd5, 5'd10), 1'b0, 0);
			issue(s_type(12'h010, 5'd6, 5'd10), 1'b0, 0);
			issue(i_type(12'h010, 5'd10, 3'd2, 5'd11, opc_load), 1'b1, 0);
			issue(i_type(12'h000, 5'd10, 3'd2, 5'd12, opc_load), 1'b1, 0);
		end
		finish_test("load_store");

		set_reg(5'd5, $random(seed));
		set_reg(5'd6, $random(seed));
		for (int r = 0; r < 6; r++) begin
			v = $random(seed);
			k = 1 + v[2:0];
			issue(r_type(7'h00, 5'd6, 5'd5, 3'd0, 5'd7), 1'b1, k);
			issue(b_type(13'h040, 5'd6, 5'd5, 3'd1), 1'b0, k);
		end
		finish_test("stall");

		$display("%0d tests, %0d failed checks", tests, tb_fails + fail_count);
		if (tb_fails + fail_count == 0) begin
			$display("Simulation passed");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

/* tb/ex_core_checker.sv */
module ex_core_checker
	import core_pkg::*;
(
	input  logic            clk,
	input  logic            rst_n,
	input  logic            instr_valid,
	input  logic [31:0]     instr,
	input  logic [xlen-1:0] pc,
	input  logic            stall,
	input  logic            wb_valid,
	input  logic [4:0]      wb_rd,
	input  logic [xlen-1:0] wb_data,
	input  logic            br_taken,
	input  logic [xlen-1:0] br_target,
	output int              fail_count
);

	// expected results of one instruction
	typedef struct packed {
		logic            wb;
		logic            br;
		logic            taken;
		logic [4:0]      rd;
		logic [xlen-1:0] data;
		logic [xlen-1:0] target;
	} expect_t;

	logic [xlen-1:0] shadow_regs [32];
	logic [xlen-1:0] shadow_mem [256];
	expect_t         s1;
	expect_t         s2;
	expect_t         s3;
	int              fails = 0;

	assign fail_count = fails;

	function automatic logic [xlen-1:0] alu_rule(input logic [2:0] f3, input logic alt,
			input logic [xlen-1:0] a, input logic [xlen-1:0] b);
		case (f3)
			3'd0: return alt ? a - b : a + b;
			3'd1: return a << b[4:0];
			3'd2: return {31'b0, $signed(a) < $signed(b)};
			3'd3: return {31'b0, a < b};
			3'd4: return a ^ b;
			3'd5: begin
				if (alt)
					return $signed(a) >>> b[4:0];
				return a >> b[4:0];
			end
			3'd6: return a | b;
			default: return a & b;
		endcase
	endfunction

	function automatic logic branch_rule(input logic [2:0] f3, input logic [xlen-1:0] a,
			input logic [xlen-1:0] b);
		case (f3)
			3'd0: return a == b;
			3'd1: return a != b;
			3'd4: return $signed(a) < $signed(b);
			3'd5: return $signed(a) >= $signed(b);
			3'd6: return a < b;
			3'd7: return a >= b;
			default: return 1'b0;
		endcase
	endfunction

	// shadow state moves at issue, the expected results follow the pipe
	always @(posedge clk) begin : predict
		logic [xlen-1:0] a;
		logic [xlen-1:0] b;
		logic [xlen-1:0] imm_i;
		logic [xlen-1:0] ld_addr;
		logic [xlen-1:0] st_addr;
		expect_t         e;
		a = (instr[19:15] == 5'd0) ? '0 : shadow_regs[instr[19:15]];
		b = (instr[24:20] == 5'd0) ? '0 : shadow_regs[instr[24:20]];
		imm_i = {{20{instr[31]}}, instr[31:20]};
		ld_addr = a + imm_i;
		st_addr = a + {{20{instr[31]}}, instr[31:25], instr[11:7]};
		e = '0;
		e.rd = instr[11:7];
		e.target = pc + {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
		if (!rst_n) begin
			s1 <= '0;
			s2 <= '0;
			s3 <= '0;
		end else if (!stall) begin
			if (instr_valid) begin
				case (instr[6:0])
					7'h37: {e.wb, e.data} = {1'b1, instr[31:12], 12'b0};
					7'h67: {e.wb, e.data} = {1'b1, pc + 32'd4};
					7'h63: {e.br, e.taken} = {1'b1, branch_rule(instr[14:12], a, b)};
					7'h03: {e.wb, e.data} = {1'b1, shadow_mem[ld_addr[9:2]]};
					7'h23: shadow_mem[st_addr[9:2]] = b;
					7'h13: begin
						e.wb = 1'b1;
						e.data = alu_rule(instr[14:12], instr[30] && instr[14:12] == 3'd5,
							a, imm_i);
					end
					7'h33: {e.wb, e.data} = {1'b1, alu_rule(instr[14:12], instr[30], a, b)};
					default: ;
				endcase
				if (e.wb && e.rd != 5'd0)
					shadow_regs[e.rd] = e.data;
			end
			s1 <= e;
			s2 <= s1;
			s3 <= s2;
		end
	end

	a_wb_valid: assert property (@(posedge clk) disable iff (!rst_n) wb_valid == s3.wb)
		else begin
			$display("[FAIL] t=%0t wb_valid expected %0b got %0b",
				$time, $sampled(s3.wb), $sampled(wb_valid));
			fails++;
		end

	a_wb_payload: assert property (@(posedge clk) disable iff (!rst_n)
		s3.wb |-> (wb_rd == s3.rd && wb_data == s3.data))
		else begin
			$display("[FAIL] t=%0t wb_rd,wb_data expected %0d,%h got %0d,%h", $time,
				$sampled(s3.rd), $sampled(s3.data), $sampled(wb_rd), $sampled(wb_data));
			fails++;
		end

	a_br_taken: assert property (@(posedge clk) disable iff (!rst_n) br_taken == s2.taken)
		else begin
			$display("[FAIL] t=%0t br_taken expected %0b got %0b",
				$time, $sampled(s2.taken), $sampled(br_taken));
			fails++;
		end

	a_br_target: assert property (@(posedge clk) disable iff (!rst_n)
		s2.br |-> br_target == s2.target)
		else begin
			$display("[FAIL] t=%0t br_target expected %h got %h",
				$time, $sampled(s2.target), $sampled(br_target));
			fails++;
		end

	// nothing at the top moves while stalled
	a_stall_hold: assert property (@(posedge clk) disable iff (!rst_n)
		stall |=> $stable({wb_valid, wb_rd, wb_data, br_taken, br_target}))
		else begin
			$display("t=%0t: a top output changed while stall was held", $time);
			fails++;
		end

endmodule

/* logic/ex_core_top.sv */
module ex_core_top
	import core_pkg::*;
(
	input  logic              clk,
	input  logic              rst_n,
	input  logic              instr_valid,
	input  logic [31:0]       instr,
	input  logic [xlen-1:0]   pc,
	input  logic              stall,
	output logic              wb_valid,
	output logic [reg_aw-1:0] wb_rd,
	output logic [xlen-1:0]   wb_data,
	output logic              br_taken,
	output logic [xlen-1:0]   br_target
);

	logic [reg_aw-1:0] rs1;
	logic [reg_aw-1:0] rs2;
	logic [xlen-1:0]   rs1_data;
	logic [xlen-1:0]   rs2_data;
	id_ex_t            id_ex;
	ex_mem_t           ex_mem;
	mem_wb_t           mem_wb;

	reg_file u_reg_file (
		.clk      (clk),
		.rs1      (rs1),
		.rs2      (rs2),
		.wb       (mem_wb),
		.stall    (stall),
		.rs1_data (rs1_data),
		.rs2_data (rs2_data)
	);

	decode_stage u_decode_stage (
		.clk         (clk),
		.rst_n       (rst_n),
		.instr_valid (instr_valid),
		.instr       (instr),
		.pc          (pc),
		.stall       (stall),
		.rs1_data    (rs1_data),
		.rs2_data    (rs2_data),
		.rs1         (rs1),
		.rs2         (rs2),
		.id_ex       (id_ex)
	);

	execute_stage u_execute_stage (
		.clk       (clk),
		.rst_n     (rst_n),
		.id_ex     (id_ex),
		.stall     (stall),
		.ex_mem    (ex_mem),
		.br_taken  (br_taken),
		.br_target (br_target)
	);

	memory_stage u_memory_stage (
		.clk    (clk),
		.rst_n  (rst_n),
		.ex_mem (ex_mem),
		.stall  (stall),
		.mem_wb (mem_wb)
	);

	assign wb_valid = mem_wb.valid;
	assign wb_rd    = mem_wb.rd;
	assign wb_data  = mem_wb.data;

endmodule

/* logic/memory_stage.sv */
module memory_stage
	import core_pkg::*;
(
	input  logic    clk,
	input  logic    rst_n,
	input  ex_mem_t ex_mem,
	input  logic    stall,
	output mem_wb_t mem_wb
);

	logic [xlen-1:0]    dmem [dmem_words];
	logic [dmem_aw-1:0] addr;
	logic [xlen-1:0]    load_data;
	logic [xlen-1:0]    wb_data;

	// word index, byte offset ignored
	assign addr      = ex_mem.alu_out[dmem_aw+1:2];
	assign load_data = dmem[addr];

	always_ff @(posedge clk) begin
		if (ex_mem.valid && ex_mem.mem_op == mem_store && !stall) begin
			dmem[addr] <= ex_mem.rs2_data;
		end
	end

	always_comb begin
		case (ex_mem.wb_sel)
			wb_alu:  wb_data = ex_mem.alu_out;
			wb_mem:  wb_data = load_data;
			wb_pc4:  wb_data = ex_mem.pc + 32'd4;
			default: wb_data = '0;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			mem_wb.valid <= 1'b0;
		end else if (!stall) begin
			mem_wb.valid <= ex_mem.valid && ex_mem.wb_sel != wb_none;
			mem_wb.rd    <= ex_mem.rd;
			mem_wb.data  <= wb_data;
		end
	end

	a_word_aligned: assert property (
		@(posedge clk) disable iff (!rst_n)
		(ex_mem.valid && ex_mem.mem_op != mem_none) |-> (ex_mem.alu_out[1:0] == 2'b00)
	);

endmodule

/* logic/execute_stage.sv */
module execute_stage
	import core_pkg::*;
(
	input  logic            clk,
	input  logic            rst_n,
	input  id_ex_t          id_ex,
	input  logic            stall,
	output ex_mem_t         ex_mem,
	output logic            br_taken,
	output logic [xlen-1:0] br_target
);

	logic [xlen-1:0] op1;
	logic [xlen-1:0] op2;
	logic [xlen-1:0] sum;
	logic [xlen-1:0] alu_out;
	logic            lt_s;
	logic            lt_u;
	logic            br_cond;
	logic            is_branch;

	assign op1  = id_ex.op1;
	assign op2  = id_ex.op2;
	assign sum  = op1 + op2;
	assign lt_s = $signed(op1) < $signed(op2);
	assign lt_u = op1 < op2;

	assign is_branch = id_ex.exe_fun inside {br_beq, br_bne, br_blt, br_bge, br_bltu, br_bgeu};

	always_comb begin
		case (id_ex.exe_fun)
			alu_add:   alu_out = sum;
			alu_sub:   alu_out = op1 - op2;
			alu_and:   alu_out = op1 & op2;
			alu_or:    alu_out = op1 | op2;
			alu_xor:   alu_out = op1 ^ op2;
			alu_sll:   alu_out = op1 << op2[4:0];
			alu_srl:   alu_out = op1 >> op2[4:0];
			alu_sra:   alu_out = $signed(op1) >>> op2[4:0];
			alu_slt:   alu_out = {{(xlen-1){1'b0}}, lt_s};
			alu_sltu:  alu_out = {{(xlen-1){1'b0}}, lt_u};
			// jump target, low bit dropped
			alu_jalr:  alu_out = {sum[xlen-1:1], 1'b0};
			alu_copy1: alu_out = op1;
			default:   alu_out = '0;
		endcase
	end

	always_comb begin
		case (id_ex.exe_fun)
			br_beq:  br_cond = (op1 == op2);
			br_bne:  br_cond = (op1 != op2);
			br_blt:  br_cond = lt_s;
			br_bge:  br_cond = !lt_s;
			br_bltu: br_cond = lt_u;
			br_bgeu: br_cond = !lt_u;
			default: br_cond = 1'b0;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			ex_mem.valid <= 1'b0;
			br_taken     <= 1'b0;
		end else if (!stall) begin
			ex_mem <= '{
				valid:    id_ex.valid,
				pc:       id_ex.pc,
				alu_out:  alu_out,
				rs2_data: id_ex.rs2_data,
				mem_op:   id_ex.mem_op,
				wb_sel:   id_ex.wb_sel,
				rd:       id_ex.rd
			};
			br_taken  <= id_ex.valid && br_cond;
			br_target <= id_ex.pc + id_ex.imm_b;
		end
	end

	// a taken flag needs a valid branch in the cycle before
	a_br_taken_src: assert property (
		@(posedge clk) disable iff (!rst_n)
		(!stall && !(id_ex.valid && is_branch)) |=> !br_taken
	);

endmodule

/* logic/decode_stage.sv */
module decode_stage
	import core_pkg::*;
(
	input  logic              clk,
	input  logic              rst_n,
	input  logic              instr_valid,
	input  logic [31:0]       instr,
	input  logic [xlen-1:0]   pc,
	input  logic              stall,
	input  logic [xlen-1:0]   rs1_data,
	input  logic [xlen-1:0]   rs2_data,
	output logic [reg_aw-1:0] rs1,
	output logic [reg_aw-1:0] rs2,
	output id_ex_t            id_ex
);

	// RV32I major opcodes handled by this slice
	typedef enum logic [6:0] {
		op_lui    = 7'b0110111,
		op_jalr   = 7'b1100111,
		op_branch = 7'b1100011,
		op_load   = 7'b0000011,
		op_store  = 7'b0100011,
		op_imm    = 7'b0010011,
		op_reg    = 7'b0110011
	} opcode_e;

	logic [6:0]      opcode;
	logic [2:0]      funct3;
	logic [xlen-1:0] imm_i;
	logic [xlen-1:0] imm_s;
	logic [xlen-1:0] imm_b;
	logic [xlen-1:0] imm_u;
	id_ex_t          nxt;

	function automatic alu_op_e alu_fun(input logic [2:0] f3, input logic alt);
		case (f3)
			3'b000: return alt ? alu_sub : alu_add;
			3'b001: return alu_sll;
			3'b010: return alu_slt;
			3'b011: return alu_sltu;
			3'b100: return alu_xor;
			3'b101: return alt ? alu_sra : alu_srl;
			3'b110: return alu_or;
			default: return alu_and;
		endcase
	endfunction

	assign opcode = instr[6:0];
	assign funct3 = instr[14:12];
	assign rs1    = instr[19:15];
	assign rs2    = instr[24:20];

	assign imm_i = {{20{instr[31]}}, instr[31:20]};
	assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
	assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
	assign imm_u = {instr[31:12], 12'b0};

	always_comb begin
		nxt          = '0;
		nxt.valid    = instr_valid;
		nxt.pc       = pc;
		nxt.exe_fun  = alu_none;
		nxt.op1      = rs1_data;
		nxt.op2      = rs2_data;
		nxt.rs2_data = rs2_data;
		nxt.imm_b    = imm_b;
		nxt.mem_op   = mem_none;
		nxt.wb_sel   = wb_none;
		nxt.rd       = instr[11:7];
		case (opcode)
			op_lui: begin
				nxt.op1     = '0;
				nxt.op2     = imm_u;
				nxt.exe_fun = alu_add;
				nxt.wb_sel  = wb_alu;
			end
			op_jalr: begin
				nxt.op2     = imm_i;
				nxt.exe_fun = alu_jalr;
				nxt.wb_sel  = wb_pc4;
			end
			op_branch: begin
				case (funct3)
					3'b000: nxt.exe_fun = br_beq;
					3'b001: nxt.exe_fun = br_bne;
					3'b100: nxt.exe_fun = br_blt;
					3'b101: nxt.exe_fun = br_bge;
					3'b110: nxt.exe_fun = br_bltu;
					3'b111: nxt.exe_fun = br_bgeu;
					default: nxt.exe_fun = alu_none;
				endcase
			end
			op_load: begin
				// word access only
				if (funct3 == 3'b010) begin
					nxt.op2     = imm_i;
					nxt.exe_fun = alu_add;
					nxt.mem_op  = mem_load;
					nxt.wb_sel  = wb_mem;
				end
			end
			op_store: begin
				if (funct3 == 3'b010) begin
					nxt.op2     = imm_s;
					nxt.exe_fun = alu_add;
					nxt.mem_op  = mem_store;
				end
			end
			op_imm: begin
				nxt.op2     = imm_i;
				nxt.exe_fun = alu_fun(funct3, instr[30] && funct3 == 3'b101);
				nxt.wb_sel  = wb_alu;
			end
			op_reg: begin
				nxt.exe_fun = alu_fun(funct3, instr[30]);
				nxt.wb_sel  = wb_alu;
			end
			default: ;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			id_ex.valid <= 1'b0;
		end else if (!stall) begin
			id_ex <= nxt;
		end
	end

endmodule

/* logic/reg_file.sv */
module reg_file
	import core_pkg::*;
(
	input  logic              clk,
	input  logic [reg_aw-1:0] rs1,
	input  logic [reg_aw-1:0] rs2,
	input  mem_wb_t           wb,
	input  logic              stall,
	output logic [xlen-1:0]   rs1_data,
	output logic [xlen-1:0]   rs2_data
);

	logic [xlen-1:0] regs [32];

	// x0 is never stored and reads as zero
	assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
	assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

	always_ff @(posedge clk) begin
		if (wb.valid && wb.rd != '0 && !stall) begin
			regs[wb.rd] <= wb.data;
		end
	end

	// x0 stays zero even right after a writeback that targets it
	a_x0_zero: assert property (
		@(posedge clk)
		(wb.valid && wb.rd == '0) |=> ((rs1 == '0) -> (rs1_data == '0))
	);

endmodule

/* logic/core_pkg.sv */
package core_pkg;

	localparam int xlen = 32;
	localparam int reg_aw = 5;
	localparam int dmem_words = 256;
	localparam int dmem_aw = $clog2(dmem_words);

	// execute functions, ALU group first, then branch compares
	typedef enum logic [4:0] {
		alu_none,
		alu_add,
		alu_sub,
		alu_and,
		alu_or,
		alu_xor,
		alu_sll,
		alu_srl,
		alu_sra,
		alu_slt,
		alu_sltu,
		alu_jalr,
		alu_copy1,
		br_beq,
		br_bne,
		br_blt,
		br_bge,
		br_bltu,
		br_bgeu
	} alu_op_e;

	typedef enum logic [1:0] {
		mem_none,
		mem_load,
		mem_store
	} mem_op_e;

	typedef enum logic [1:0] {
		wb_none,
		wb_alu,
		wb_mem,
		wb_pc4
	} wb_sel_e;

	typedef struct packed {
		logic               valid;
		logic [xlen-1:0]    pc;
		alu_op_e            exe_fun;
		logic [xlen-1:0]    op1;
		logic [xlen-1:0]    op2;
		logic [xlen-1:0]    rs2_data;
		logic [xlen-1:0]    imm_b;
		mem_op_e            mem_op;
		wb_sel_e            wb_sel;
		logic [reg_aw-1:0]  rd;
	} id_ex_t;

	typedef struct packed {
		logic               valid;
		logic [xlen-1:0]    pc;
		logic [xlen-1:0]    alu_out;
		logic [xlen-1:0]    rs2_data;
		mem_op_e            mem_op;
		wb_sel_e            wb_sel;
		logic [reg_aw-1:0]  rd;
	} ex_mem_t;

	typedef struct packed {
		logic               valid;
		logic [reg_aw-1:0]  rd;
		logic [xlen-1:0]    data;
	} mem_wb_t;

endpackage
